// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_cnn_seq -Mdir obj_dir -o tb_cnn_seq_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_cnn_seq_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sources.f
+incdir+src
src/cnn_seq_pkg.sv
src/res_ram.sv
src/res_bank_arbiter.sv
src/result_writeback.sv
src/window_fetch.sv
src/layer_sequencer.sv
src/cnn_seq_top.sv
testbench/tb_cnn_seq.sv

// File: src/cnn_seq_cfg.svh
/* CNN sequencer sizes and command codes */
`ifndef CNN_SEQ_CFG_SVH
`define CNN_SEQ_CFG_SVH

// Run geometry
`define CNN_NUM_BLOCKS        4     // 4x4 blocks per filter
`define CNN_NUM_FILTERS       2
`define CNN_MAC_COUNT         9     // Operand beats per block
`define CNN_PARAMS_PER_FILTER 10    // Bias + 3x3 weights

// Command words
`define CNN_START_CMD         32'h2
`define CNN_SSFR_CMD          8'hC1 // ReLU/maxpool config
`define CNN_SSFR_PARAM        8'h28

// Address widths
`define CNN_IMG_AW            10    // Image banks
`define CNN_CONV_AW           15    // Weight memory
`define CNN_RES_AW            8     // One residue bank

`endif

// File: src/cnn_seq_pkg.sv
/* CNN sequencer types */
`include "cnn_seq_cfg.svh"

package cnn_seq_pkg;

    // Operand beat, pix[0] sits in the top byte
    typedef struct packed {
        logic [0:3][7:0] pix;   // Four pixels of one MAC step
        logic [7:0]      param; // Weight or bias
    } beat_op_s;

    // Header and config beats
    typedef struct packed {
        logic [7:0]  cmd_hi;    // MAC count high byte / SSFR opcode
        logic [7:0]  cmd_lo;    // MAC count low byte
        logic [15:0] unused;
        logic [7:0]  param;
    } beat_cmd_s;

    // One NPU beat word, read as operands or as a command
    typedef union packed {
        beat_op_s  op;
        beat_cmd_s cmd;
    } npu_beat_u;

    // Sequencer state seen by the fetch unit
    typedef struct packed {
        logic [3:0]                            step;   // 0..13 within a block
        logic [$clog2(`CNN_NUM_BLOCKS)-1:0]    block;
        logic                                  active; // Run in progress
    } seq_ctrl_s;

    // Residue bank access request
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [1:0]             bank;
        logic [`CNN_RES_AW-1:0] addr;
        logic [7:0]             data;
    } res_req_s;

endpackage

// File: src/cnn_seq_top.sv
/* CNN memory-side sequencer */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module cnn_seq_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              control_reg,   // Command word
    // Image and weight memories
    output logic [`CNN_IMG_AW-1:0]   image_ram_addr,
    input  logic [3:0][7:0]          read_image,    // One byte per bank
    output logic [`CNN_CONV_AW-1:0]  conv_ram_addr,
    input  logic [7:0]               read_conv,
    // NPU stream
    output cnn_seq_pkg::npu_beat_u   beat,
    output logic                     op_valid,
    output logic                     en_config,
    output logic                     en_fsm,
    output logic                     busy,
    input  logic [7:0]               d_out,         // NPU result
    input  logic                     result_valid,
    // Wishbone classic slave
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`CNN_RES_AW+1:0]   wb_adr,
    input  logic [7:0]               wb_dat_i,
    output logic [7:0]               wb_dat_o,
    output logic                     wb_ack
);

    cnn_seq_pkg::seq_ctrl_s ctrl;      // Step and block to fetch
    cnn_seq_pkg::res_req_s  res_req;   // Write-back request
    logic                   res_grant;

    layer_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .control_reg   (control_reg),
        .ctrl          (ctrl),
        .conv_ram_addr (conv_ram_addr),
        .en_fsm        (en_fsm),
        .en_config     (en_config),
        .op_valid      (op_valid),
        .busy          (busy)
    );

    window_fetch u_fetch (
        .clk            (clk),
        .reset          (reset),
        .ctrl           (ctrl),
        .read_image     (read_image),
        .read_conv      (read_conv),
        .image_ram_addr (image_ram_addr),
        .beat           (beat)
    );

    result_writeback u_wb (
        .clk          (clk),
        .reset        (reset),
        .d_out        (d_out),
        .result_valid (result_valid),
        .grant        (res_grant),
        .req          (res_req)
    );

    res_bank_arbiter u_arb (
        .clk      (clk),
        .reset    (reset),
        .wb_req   (res_req),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_grant (res_grant),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

endmodule

// File: src/layer_sequencer.sv
/* Layer run sequencer */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module layer_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             control_reg,
    output cnn_seq_pkg::seq_ctrl_s  ctrl,
    output logic [`CNN_CONV_AW-1:0] conv_ram_addr,
    output logic                    en_fsm,
    output logic                    en_config,
    output logic                    op_valid,
    output logic                    busy
);

    localparam int CAW = `CNN_CONV_AW;
    localparam int BW  = $clog2(`CNN_NUM_BLOCKS);
    localparam int FW  = $clog2(`CNN_NUM_FILTERS);

    logic           running;     // Idle / run
    logic [3:0]     step;        // Position within one block
    logic [BW-1:0]  block;
    logic [FW-1:0]  filter;
    logic [CAW-1:0] param_base;  // Bias address of current filter
    logic           start;
    logic           last_step, last_block, last_filter;

    assign start       = !running && (control_reg == `CNN_START_CMD);
    assign last_step   = (step == 4'd13);
    assign last_block  = (block == BW'(`CNN_NUM_BLOCKS - 1));
    assign last_filter = (filter == FW'(`CNN_NUM_FILTERS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            running       <= 1'b0;
            step          <= '0;
            block         <= '0;
            filter        <= '0;
            param_base    <= '0;
            conv_ram_addr <= '0;
            en_fsm        <= 1'b0;
            op_valid      <= 1'b0;
            en_config     <= 1'b0;
        end else begin
            en_fsm    <= 1'b0;
            // Beats are registered in fetch, so these line up with them
            op_valid  <= running && (step >= 4'd2) && (step <= 4'd11); // Header + 9 operands
            en_config <= running && (step == 4'd12);                   // SSFR beat

            if (start) begin
                running    <= 1'b1;
                step       <= '0;
                block      <= '0;
                filter     <= '0;
                param_base <= '0;
                en_fsm     <= 1'b1;  // First block
            end else if (running) begin
                // Weight address leads its beat by one cycle
                if (step < 4'd10)
                    conv_ram_addr <= param_base + CAW'(step);

                if (last_step) begin
                    step <= '0;
                    if (last_block) begin
                        block <= '0;
                        if (last_filter) begin
                            running <= 1'b0;  // Run done
                            filter  <= '0;
                        end else begin
                            filter     <= filter + 1'b1;
                            param_base <= param_base + CAW'(`CNN_PARAMS_PER_FILTER);
                        end
                    end else begin
                        block <= block + 1'b1;
                    end
                    en_fsm <= !(last_block && last_filter);  // Next block starts
                end else begin
                    step <= step + 4'd1;
                end
            end
        end
    end

    assign busy = running;
    assign ctrl = '{step: step, block: block, active: running};

    // Block sequence is 14 steps long
    a_step_range: assert property (@(posedge clk) disable iff (reset)
        step <= 4'd13);

endmodule

// File: src/res_bank_arbiter.sv
/* Residue bank arbiter and Wishbone read port */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module res_bank_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  cnn_seq_pkg::res_req_s  wb_req,    // From write-back
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`CNN_RES_AW+1:0] wb_adr,    // {residue addr, bank}
    input  logic [7:0]             wb_dat_i,
    output logic                   wb_grant,
    output logic [7:0]             wb_dat_o,
    output logic                   wb_ack
);

    cnn_seq_pkg::res_req_s host_req;  // Wishbone request in bank form
    cnn_seq_pkg::res_req_s sel;       // Access driven onto the banks
    logic                  host_go;   // Host access issued this cycle
    logic                  rd_pend;   // Bank data valid, ack due
    logic [1:0]            rd_bank;
    logic [3:0][7:0]       bank_q;

    assign host_req = '{req:  wb_cyc & wb_stb,
                        we:   wb_we,
                        bank: wb_adr[1:0],
                        addr: wb_adr[`CNN_RES_AW+1:2],
                        data: wb_dat_i};

    assign wb_grant = wb_req.req;                          // Write-back first
    assign host_go  = host_req.req & ~wb_grant & ~rd_pend;
    assign sel      = wb_grant ? wb_req : host_req;

    for (genvar i = 0; i < 4; i++) begin : g_bank
        res_ram u_bank (
            .clk   (clk),
            .addr  (sel.addr),
            .wdata (sel.data),
            .we    (wb_grant & sel.we & (sel.bank == 2'(i))),  // Host writes dropped
            .rdata (bank_q[i])
        );
    end

    always_ff @(posedge clk) begin
        if (reset)
            rd_pend <= 1'b0;
        else
            rd_pend <= host_go;  // One-cycle read latency
    end

    always_ff @(posedge clk) begin
        if (host_go)
            rd_bank <= host_req.bank;
    end

    assign wb_dat_o = bank_q[rd_bank];
    assign wb_ack   = rd_pend & wb_cyc & wb_stb;  // Abandoned if strobe dropped

    // Each host access is acked once
    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

// File: src/res_ram.sv
/* Residue bank, single port */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module res_ram (
    input  logic                   clk,
    input  logic [`CNN_RES_AW-1:0] addr,
    input  logic [7:0]             wdata,
    input  logic                   we,
    output logic [7:0]             rdata
);

    logic [7:0] mem [2**`CNN_RES_AW];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];  // Registered read, old data on write
    end

endmodule

// File: src/result_writeback.sv
/* NPU result write-back */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module result_writeback (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             d_out,
    input  logic                   result_valid,
    input  logic                   grant,
    output cnn_seq_pkg::res_req_s  req
);

    logic                   pending;  // Result waiting for a bank slot
    logic [1:0]             bank;     // Rotates 0..3
    logic [`CNN_RES_AW-1:0] addr;
    logic [7:0]             data;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            bank    <= '0;
            addr    <= '0;
        end else begin
            if (pending && grant) begin
                pending <= 1'b0;
                bank    <= bank + 2'd1;
                if (bank == 2'd3)
                    addr <= addr + 1'b1;  // Next row across the banks
            end
            if (result_valid)
                pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid)
            data <= d_out;
    end

    assign req = '{req: pending, we: 1'b1, bank: bank, addr: addr, data: data};

    // NPU spacing must leave time for the grant
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> !pending);

endmodule

// File: src/window_fetch.sv
/* Image block fetch and NPU beat builder */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module window_fetch (
    input  logic                    clk,
    input  logic                    reset,
    input  cnn_seq_pkg::seq_ctrl_s  ctrl,
    input  logic [3:0][7:0]         read_image,   // Bank k in byte k
    input  logic [7:0]              read_conv,
    output logic [`CNN_IMG_AW-1:0]  image_ram_addr,
    output cnn_seq_pkg::npu_beat_u  beat
);

    localparam int IAW = `CNN_IMG_AW;

    // Pixel indices of the nine 2x2 taps, pixel 4r+k is row r bank k
    localparam logic [0:8][0:3][3:0] TAPS = {
        {4'd0,  4'd1,  4'd2,  4'd3},
        {4'd1,  4'd4,  4'd3,  4'd6},
        {4'd4,  4'd5,  4'd6,  4'd7},
        {4'd2,  4'd3,  4'd8,  4'd9},
        {4'd3,  4'd6,  4'd9,  4'd12},
        {4'd6,  4'd7,  4'd12, 4'd13},
        {4'd8,  4'd9,  4'd10, 4'd11},
        {4'd9,  4'd12, 4'd11, 4'd14},
        {4'd12, 4'd13, 4'd14, 4'd15}
    };

    logic [7:0]             blk_buf [16];  // 4x4 block
    logic [1:0]             row;           // Row being captured
    logic [3:0]             tap_j;         // Operand beat index 0..8
    cnn_seq_pkg::npu_beat_u beat_d;

    assign row   = ctrl.step[1:0] - 2'd2;  // Steps 2..5 -> rows 0..3
    assign tap_j = ctrl.step - 4'd3;

    // Row r of block b lives at word 4b+r
    always_ff @(posedge clk) begin
        if (reset)
            image_ram_addr <= '0;
        else if (ctrl.active && ctrl.step < 4'd4)
            image_ram_addr <= IAW'({ctrl.block, ctrl.step[1:0]});
    end

    // Data arrives two steps after the row address was chosen
    always_ff @(posedge clk) begin
        if (ctrl.active && ctrl.step >= 4'd2 && ctrl.step <= 4'd5) begin
            for (int k = 0; k < 4; k++)
                blk_buf[{row, 2'(k)}] <= read_image[k];
        end
    end

    always_comb begin
        beat_d = beat;  // Hold between beats
        if (ctrl.active) begin
            if (ctrl.step == 4'd2) begin
                // Header with MAC count and bias
                beat_d.cmd = '{cmd_hi: 8'd0, cmd_lo: 8'(`CNN_MAC_COUNT),
                               unused: 16'd0, param: read_conv};
            end else if (ctrl.step >= 4'd3 && ctrl.step <= 4'd11) begin
                for (int k = 0; k < 4; k++)
                    beat_d.op.pix[k] = blk_buf[TAPS[tap_j][k]];
                beat_d.op.param = read_conv;  // Weight j
            end else if (ctrl.step == 4'd12) begin
                beat_d.cmd = '{cmd_hi: `CNN_SSFR_CMD, cmd_lo: 8'd0,
                               unused: 16'd0, param: `CNN_SSFR_PARAM};
            end
        end
    end

    always_ff @(posedge clk) begin
        beat <= beat_d;
    end

endmodule

// File: testbench/tb_cnn_seq.sv
/* CNN sequencer testbench */
`timescale 1ns/1ps
`include "cnn_seq_cfg.svh"

module tb_cnn_seq;

    localparam int NUM_RESULTS    = `CNN_NUM_BLOCKS * `CNN_NUM_FILTERS;
    localparam int BEAT_TIMEOUT   = 30;   // Cycles to the next header beat
    localparam int CONFIG_TIMEOUT = 40;   // Cycles to the next config beat
    localparam int ACK_TIMEOUT    = 20;   // Cycles to a Wishbone ack

    // One NPU result and where it must land
    typedef struct packed {
        logic [7:0]             d_out;   // Driven on the NPU result port
        logic [`CNN_RES_AW+1:0] wb_adr;  // {residue addr, bank}
        logic [7:0]             data;    // Expected readback
    } res_entry_s;

    // Result n goes to bank n mod 4, address n div 4
    res_entry_s result_table [NUM_RESULTS] = '{
        '{8'h3C, 10'h000, 8'h3C},
        '{8'hA5, 10'h001, 8'hA5},
        '{8'h01, 10'h002, 8'h01},
        '{8'hFF, 10'h003, 8'hFF},
        '{8'h7E, 10'h004, 8'h7E},
        '{8'h80, 10'h005, 8'h80},
        '{8'h5A, 10'h006, 8'h5A},
        '{8'hC3, 10'h007, 8'hC3}
    };

    // Pixel indices of operand beats 1..9
    int tap_idx [9][4] = '{
        '{0, 1, 2, 3},   '{1, 4, 3, 6},   '{4, 5, 6, 7},
        '{2, 3, 8, 9},   '{3, 6, 9, 12},  '{6, 7, 12, 13},
        '{8, 9, 10, 11}, '{9, 12, 11, 14}, '{12, 13, 14, 15}
    };

    logic                     clk = 1'b0;
    logic                     reset;
    logic [31:0]              control_reg;
    logic [`CNN_IMG_AW-1:0]   image_ram_addr;
    logic [3:0][7:0]          read_image = '0;
    logic [`CNN_CONV_AW-1:0]  conv_ram_addr;
    logic [7:0]               read_conv = '0;
    cnn_seq_pkg::npu_beat_u   beat;
    logic                     op_valid;
    logic                     en_config;
    logic                     en_fsm;
    logic                     busy;
    logic [7:0]               d_out;
    logic                     result_valid;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`CNN_RES_AW+1:0]   wb_adr;
    logic [7:0]               wb_dat_i;
    logic [7:0]               wb_dat_o;
    logic                     wb_ack;

    // Memory models
    logic [7:0]               img_mem [4][2**`CNN_IMG_AW];
    logic [7:0]               conv_mem [2**`CNN_CONV_AW];
    logic [`CNN_IMG_AW-1:0]   img_addr_q;
    logic [`CNN_CONV_AW-1:0]  conv_addr_q;

    integer seed;
    int     config_count = 0;  // Config beats seen so far

    cnn_seq_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .control_reg    (control_reg),
        .image_ram_addr (image_ram_addr),
        .read_image     (read_image),
        .conv_ram_addr  (conv_ram_addr),
        .read_conv      (read_conv),
        .beat           (beat),
        .op_valid       (op_valid),
        .en_config      (en_config),
        .en_fsm         (en_fsm),
        .busy           (busy),
        .d_out          (d_out),
        .result_valid   (result_valid),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack         (wb_ack)
    );

    always #5 clk = ~clk;  // 10 ns period

    // Address taken mid-cycle, data one cycle later
    always @(negedge clk) begin
        img_addr_q  <= image_ram_addr;
        conv_addr_q <= conv_ram_addr;
    end

    always @(posedge clk) begin
        #1;
        for (int k = 0; k < 4; k++)
            read_image[k] = img_mem[k][img_addr_q];
        read_conv = conv_mem[conv_addr_q];
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [39:0] got,
                               input logic [39:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("MISMATCH at %0t: %s = %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    // Pixel 4r+k of block b is bank k, word 4b+r
    function automatic logic [7:0] pixel(input int b, input int p);
        return img_mem[p % 4][4 * b + p / 4];
    endfunction

    function automatic cnn_seq_pkg::npu_beat_u header_beat(input int f);
        cnn_seq_pkg::npu_beat_u exp;
        exp.cmd.cmd_hi = 8'h00;
        exp.cmd.cmd_lo = 8'(`CNN_MAC_COUNT);
        exp.cmd.unused = 16'h0000;
        exp.cmd.param  = conv_mem[f * `CNN_PARAMS_PER_FILTER];  // Bias
        return exp;
    endfunction

    function automatic cnn_seq_pkg::npu_beat_u operand_beat(input int f, input int b,
                                                            input int j);
        cnn_seq_pkg::npu_beat_u exp;
        for (int k = 0; k < 4; k++)
            exp.op.pix[k] = pixel(b, tap_idx[j-1][k]);
        exp.op.param = conv_mem[f * `CNN_PARAMS_PER_FILTER + j];
        return exp;
    endfunction

    function automatic cnn_seq_pkg::npu_beat_u config_beat();
        cnn_seq_pkg::npu_beat_u exp;
        exp.cmd.cmd_hi = `CNN_SSFR_CMD;
        exp.cmd.cmd_lo = 8'h00;
        exp.cmd.unused = 16'h0000;
        exp.cmd.param  = `CNN_SSFR_PARAM;
        return exp;
    endfunction

    // Follows the beat stream of a whole run, sampled mid-cycle
    task automatic check_run();
        int   wait_cnt;
        logic more;  // Another block follows
        for (int f = 0; f < `CNN_NUM_FILTERS; f++) begin
            for (int b = 0; b < `CNN_NUM_BLOCKS; b++) begin
                wait_cnt = 0;
                @(negedge clk);
                while (!op_valid) begin
                    wait_cnt++;
                    assert (wait_cnt <= BEAT_TIMEOUT) else
                        fail_run($sformatf("No header beat for filter %0d block %0d", f, b));
                    @(negedge clk);
                end
                check_value("beat", beat, header_beat(f));
                check_value("en_fsm", en_fsm, 1'b0);  // Strobe is one cycle
                for (int j = 1; j <= `CNN_MAC_COUNT; j++) begin
                    @(negedge clk);
                    check_value("op_valid", op_valid, 1'b1);
                    check_value("beat", beat, operand_beat(f, b, j));
                end
                @(negedge clk);
                check_value("en_config", en_config, 1'b1);
                check_value("op_valid", op_valid, 1'b0);
                check_value("beat", beat, config_beat());
                check_value("busy", busy, 1'b1);
                config_count++;
                more = (f < `CNN_NUM_FILTERS - 1) || (b < `CNN_NUM_BLOCKS - 1);
                @(negedge clk);
                check_value("en_fsm", en_fsm, more);  // Next block starts
                check_value("busy", busy, more);      // Run over after the last block
            end
        end
    endtask

    task automatic wb_read_check(input logic [`CNN_RES_AW+1:0] adr, input logic [7:0] exp);
        int wait_cnt;
        wait_cnt = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack) begin
            wait_cnt++;
            assert (wait_cnt <= ACK_TIMEOUT) else
                fail_run($sformatf("No Wishbone ack for the read of address %0h", adr));
            @(negedge clk);
        end
        check_value("wb_dat_o", wb_dat_o, exp);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wb_write_ack(input logic [`CNN_RES_AW+1:0] adr, input logic [7:0] data);
        int wait_cnt;
        wait_cnt = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        @(negedge clk);
        while (!wb_ack) begin
            wait_cnt++;
            assert (wait_cnt <= ACK_TIMEOUT) else
                fail_run($sformatf("No Wishbone ack for the write of address %0h", adr));
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // One result per config beat, then a read in the grant cycle
    task automatic drive_results();
        int wait_cnt;
        int gap;
        for (int n = 0; n < NUM_RESULTS; n++) begin
            wait_cnt = 0;
            while (config_count <= n) begin
                wait_cnt++;
                assert (wait_cnt <= CONFIG_TIMEOUT) else
                    fail_run($sformatf("No config beat before result %0d", n));
                @(posedge clk);
                #1;
            end
            gap = 2 + ($random(seed) & 3);  // 2..5 cycles
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            d_out        = result_table[n].d_out;
            result_valid = 1'b1;
            @(posedge clk);
            #1;
            result_valid = 1'b0;
            wb_read_check(result_table[n].wb_adr, result_table[n].data);  // Meets the write
        end
    endtask

    initial begin
        logic [31:0] idle_cmd;
        seed         = 66;
        reset        = 1'b1;
        control_reg  = 32'h0;
        d_out        = 8'h00;
        result_valid = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_i     = 8'h00;

        for (int k = 0; k < 4; k++)
            for (int a = 0; a < 2**`CNN_IMG_AW; a++)
                img_mem[k][a] = 8'($random(seed));
        for (int a = 0; a < 2**`CNN_CONV_AW; a++)
            conv_mem[a] = 8'($random(seed));

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("op_valid", op_valid, 1'b0);
        check_value("en_config", en_config, 1'b0);
        check_value("en_fsm", en_fsm, 1'b0);
        check_value("busy", busy, 1'b0);
        check_value("wb_ack", wb_ack, 1'b0);
        check_value("image_ram_addr", image_ram_addr, '0);
        check_value("conv_ram_addr", conv_ram_addr, '0);

        // Anything but the start command leaves the sequencer idle
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            idle_cmd = $random(seed);
            if (idle_cmd == `CNN_START_CMD)
                idle_cmd = 32'h0;
            control_reg = idle_cmd;
            @(negedge clk);
            check_value("busy", busy, 1'b0);
            check_value("op_valid", op_valid, 1'b0);
            check_value("en_config", en_config, 1'b0);
        end

        @(posedge clk);
        #1;
        control_reg = `CNN_START_CMD;
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        @(posedge clk);
        #1;
        control_reg = 32'h0;  // Single start pulse
        @(negedge clk);
        check_value("busy", busy, 1'b1);
        check_value("en_fsm", en_fsm, 1'b1);  // First block starts

        fork
            check_run();
            drive_results();
        join

        // Readback after the run, last result first
        for (int i = NUM_RESULTS - 1; i >= 0; i--) begin
            @(posedge clk);
            #1;
            wb_read_check(result_table[i].wb_adr, result_table[i].data);
        end

        // Host write is acked but leaves the bank alone
        @(posedge clk);
        #1;
        wb_write_ack(result_table[0].wb_adr, ~result_table[0].data);
        @(posedge clk);
        #1;
        wb_read_check(result_table[0].wb_adr, result_table[0].data);

        $display("TEST PASS");
        $finish;
    end

endmodule
